/* compile.f */
mcast_xbar_pkg.sv
mcast_addr_decoder.sv
mcast_demux.sv
mcast_arbiter.sv
mcast_xbar_top.sv
mcast_xbar_chk.sv
mcast_xbar_tb.sv

/* mcast_addr_decoder.sv */
// Combinational address decoder; maps an address and multicast mask to a target-select mask
module mcast_addr_decoder
  import mcast_xbar_pkg::*;
#(
  // Initiator this decoder serves, selects the connectivity row
  parameter init_idx_t INIT_IDX = '0
) (
  input  addr_t     addr_i,
  input  addr_t     mask_i,
  output tgt_mask_t sel_o,
  output logic      dec_err_o
);

  addr_t     offset;
  logic      in_window;
  tgt_idx_t  idx_field;
  tgt_idx_t  idx_care;
  tgt_mask_t match;

  // Position of the address inside the mapped window
  assign offset    = addr_i - MAP_BASE;
  assign in_window = (addr_i >= MAP_BASE) && (offset < MAP_SIZE);

  // Target index field, and the index bits the mask does not wildcard
  assign idx_field = offset[TGT_SHIFT +: TGT_IDX_W];
  assign idx_care  = ~mask_i[TGT_SHIFT +: TGT_IDX_W];

  // A target matches when every cared-for index bit agrees with its own index
  always_comb begin
    for (int t = 0; t < NUM_TGT; t++) begin
      match[t] = in_window && (((idx_field ^ tgt_idx_t'(t)) & idx_care) == '0);
    end
  end

  // Paths missing from the connectivity matrix drop out here
  assign sel_o = match & CONNECTIVITY[INIT_IDX];

  // Nothing left to write to, so the built-in error responder answers
  assign dec_err_o = (sel_o == '0);

endmodule

/* mcast_arbiter.sv */
// Per-target round-robin arbiter; forwards one initiator's write and routes the response back
module mcast_arbiter
  import mcast_xbar_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // Request paths from the demuxes
  input  logic  [NUM_INIT-1:0] req_valid_i,
  output logic  [NUM_INIT-1:0] req_ready_o,
  input  addr_t [NUM_INIT-1:0] addr_i,
  input  data_t [NUM_INIT-1:0] data_i,
  // Response paths to the demuxes
  output logic  [NUM_INIT-1:0] rsp_valid_o,
  output resp_t                rsp_o,
  input  logic  [NUM_INIT-1:0] rsp_ready_i,
  // Target port
  output logic                 tgt_req_valid_o,
  output addr_t                tgt_addr_o,
  output data_t                tgt_data_o,
  input  logic                 tgt_req_ready_i,
  input  logic                 tgt_rsp_valid_i,
  input  resp_t                tgt_rsp_i,
  output logic                 tgt_rsp_ready_o
);

  init_idx_t rr_ptr_q;
  logic      lock_q;
  init_idx_t lock_idx_q;
  init_idx_t grant;
  init_idx_t cand;
  logic      found;
  logic      any_valid;
  init_idx_t owner;
  logic      rsp_hs;

  assign any_valid = |req_valid_i;

  // First requester at or after the pointer
  always_comb begin
    grant = rr_ptr_q;
    cand  = rr_ptr_q;
    found = 1'b0;
    for (int k = 0; k < NUM_INIT; k++) begin
      cand = init_idx_t'((int'(rr_ptr_q) + k) % NUM_INIT);
      if (!found && req_valid_i[cand]) begin
        grant = cand;
        found = 1'b1;
      end
    end
  end

  // Lock is taken on the first offered cycle so the target sees a stable request
  assign owner = lock_q ? lock_idx_q : grant;

  assign tgt_req_valid_o = lock_q ? req_valid_i[lock_idx_q] : any_valid;
  assign tgt_addr_o      = addr_i[owner];
  assign tgt_data_o      = data_i[owner];

  // Response belongs to the locked initiator only
  assign rsp_o           = tgt_rsp_i;
  assign tgt_rsp_ready_o = lock_q && rsp_ready_i[lock_idx_q];
  assign rsp_hs          = tgt_rsp_valid_i && tgt_rsp_ready_o;

  always_comb begin
    for (int i = 0; i < NUM_INIT; i++) begin
      req_ready_o[i] = tgt_req_ready_i && (owner == init_idx_t'(i));
      rsp_valid_o[i] = lock_q && tgt_rsp_valid_i && (lock_idx_q == init_idx_t'(i));
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr_q   <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (!lock_q) begin
      if (any_valid) begin
        lock_q     <= 1'b1;
        lock_idx_q <= grant;
      end
    end else if (rsp_hs) begin
      // Write finished, next turn starts past the winner
      lock_q   <= 1'b0;
      rr_ptr_q <= init_idx_t'((int'(lock_idx_q) + 1) % NUM_INIT);
    end
  end

endmodule

/* mcast_demux.sv */
// Per-initiator demux; issues a write to its selected targets and merges their responses
module mcast_demux
  import mcast_xbar_pkg::*;
(
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Initiator request channel
  input  logic                init_req_valid_i,
  input  addr_t               init_addr_i,
  input  data_t               init_data_i,
  output logic                init_req_ready_o,
  // Initiator response channel
  output logic                init_rsp_valid_o,
  output resp_t               init_rsp_o,
  input  logic                init_rsp_ready_i,
  // Decoder result for the request on the initiator port
  input  tgt_mask_t           sel_i,
  input  logic                dec_err_i,
  // Request paths toward the target arbiters
  output tgt_mask_t           req_valid_o,
  input  tgt_mask_t           req_ready_i,
  output addr_t               addr_o,
  output data_t               data_o,
  // Response paths back from the target arbiters
  input  tgt_mask_t           rsp_valid_i,
  input  resp_t [NUM_TGT-1:0] rsp_i,
  output tgt_mask_t           rsp_ready_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_COLLECT,
    ST_RESPOND
  } state_e;

  state_e    state_q, state_d;
  tgt_mask_t issue_q, issue_d;
  tgt_mask_t pend_q, pend_d;
  resp_t     merged_q, merged_d;
  addr_t     addr_q;
  data_t     data_q;
  logic      req_hs;
  logic      collecting;
  tgt_mask_t rsp_hs;

  // Only one write in flight, so a new one is taken only when idle
  assign init_req_ready_o = (state_q == ST_IDLE);
  assign req_hs           = init_req_valid_i && init_req_ready_o;

  // Targets may answer as soon as their request is out, even while others still wait
  assign collecting  = (state_q == ST_ISSUE) || (state_q == ST_COLLECT);
  assign req_valid_o = (state_q == ST_ISSUE) ? issue_q : '0;
  assign rsp_ready_o = collecting ? pend_q : '0;
  assign rsp_hs      = rsp_valid_i & rsp_ready_o;

  assign addr_o = addr_q;
  assign data_o = data_q;

  assign init_rsp_valid_o = (state_q == ST_RESPOND);
  assign init_rsp_o       = merged_q;

  always_comb begin
    state_d  = state_q;
    issue_d  = issue_q;
    pend_d   = pend_q & ~rsp_hs;
    merged_d = merged_q;

    // Worst code wins: DECERR over SLVERR over OKAY
    for (int t = 0; t < NUM_TGT; t++) begin
      if (rsp_hs[t] && (rsp_i[t] > merged_d)) begin
        merged_d = rsp_i[t];
      end
    end

    case (state_q)
      ST_IDLE: begin
        if (req_hs) begin
          if (dec_err_i) begin
            // No target sees an unmapped write
            merged_d = RESP_DECERR;
            state_d  = ST_RESPOND;
          end else begin
            issue_d  = sel_i;
            pend_d   = sel_i;
            merged_d = RESP_OKAY;
            state_d  = ST_ISSUE;
          end
        end
      end
      ST_ISSUE: begin
        issue_d = issue_q & ~req_ready_i;
        if (issue_d == '0) begin
          state_d = ST_COLLECT;
        end
      end
      ST_COLLECT: begin
        if (pend_d == '0) begin
          state_d = ST_RESPOND;
        end
      end
      ST_RESPOND: begin
        if (init_rsp_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= ST_IDLE;
      issue_q  <= '0;
      pend_q   <= '0;
      merged_q <= RESP_OKAY;
    end else begin
      state_q  <= state_d;
      issue_q  <= issue_d;
      pend_q   <= pend_d;
      merged_q <= merged_d;
    end
  end

  // Write payload, held for all targets of a multicast
  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      addr_q <= init_addr_i;
      data_q <= init_data_i;
    end
  end

endmodule

/* mcast_xbar_chk.sv */
// Protocol assertions for the crossbar top level; attached to every mcast_xbar_top by bind
module mcast_xbar_chk
  import mcast_xbar_pkg::*;
(
  input logic                 clk_i,
  input logic                 arst_n_i,
  input tgt_mask_t            tgt_req_valid_o,
  input addr_t [NUM_TGT-1:0]  tgt_addr_o,
  input data_t [NUM_TGT-1:0]  tgt_data_o,
  input tgt_mask_t            tgt_req_ready_i,
  input logic [NUM_INIT-1:0]  init_rsp_valid_o,
  input resp_t [NUM_INIT-1:0] init_rsp_o,
  input logic [NUM_INIT-1:0]  init_rsp_ready_i
);

  // Count of failed assertions
  int fail_cnt = 0;

  for (genvar t = 0; t < NUM_TGT; t++) begin : gen_tgt
    // Target request holds until the target takes it
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      tgt_req_valid_o[t] && !tgt_req_ready_i[t] |=>
        tgt_req_valid_o[t] && $stable(tgt_addr_o[t]) && $stable(tgt_data_o[t]))
    else begin
      fail_cnt++;
      $error("target %0d request changed before it was accepted", t);
    end
  end

  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_init
    // Stalled response keeps its code
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      init_rsp_valid_o[i] && !init_rsp_ready_i[i] |=>
        init_rsp_valid_o[i] && $stable(init_rsp_o[i]))
    else begin
      fail_cnt++;
      $error("initiator %0d response changed under back-pressure", i);
    end
  end

  assert property (@(posedge clk_i)
    !arst_n_i |-> (tgt_req_valid_o == '0) && (init_rsp_valid_o == '0))
  else begin
    fail_cnt++;
    $error("valid output high during reset");
  end

endmodule

bind mcast_xbar_top mcast_xbar_chk u_chk (
  .clk_i            ( clk_i            ),
  .arst_n_i         ( arst_n_i         ),
  .tgt_req_valid_o  ( tgt_req_valid_o  ),
  .tgt_addr_o       ( tgt_addr_o       ),
  .tgt_data_o       ( tgt_data_o       ),
  .tgt_req_ready_i  ( tgt_req_ready_i  ),
  .init_rsp_valid_o ( init_rsp_valid_o ),
  .init_rsp_o       ( init_rsp_o       ),
  .init_rsp_ready_i ( init_rsp_ready_i )
);

/* mcast_xbar_pkg.sv */
// Shared sizes, types, response codes and address map; imported by every crossbar module
package mcast_xbar_pkg;

  // Port counts
  localparam int NUM_INIT = 2;
  localparam int NUM_TGT  = 4;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Width of the target index field inside an address
  localparam int TGT_IDX_W = $clog2(NUM_TGT);

  // Byte address; the multicast mask uses the same layout
  typedef logic [ADDR_W-1:0] addr_t;

  // Write data word
  typedef logic [DATA_W-1:0] data_t;

  // One bit per target port
  typedef logic [NUM_TGT-1:0] tgt_mask_t;

  // Index of a target inside the mapped window
  typedef logic [TGT_IDX_W-1:0] tgt_idx_t;

  // Index of an initiator port
  typedef logic [$clog2(NUM_INIT)-1:0] init_idx_t;

  // Write response code, AXI encoding
  typedef logic [1:0] resp_t;

  // Ordered so that the numerically larger code is the worse outcome
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;
  localparam resp_t RESP_DECERR = 2'b11;

  // Global address map
  // Target t owns MAP_BASE + t * TGT_SPAN, each region 4 KiB
  localparam addr_t MAP_BASE  = 32'h0001_0000;
  localparam int    TGT_SHIFT = 12;
  localparam int    TGT_SPAN  = 4096;

  // Size of the whole mapped window
  localparam addr_t MAP_SIZE = addr_t'(NUM_TGT * TGT_SPAN);

  // Connectivity matrix, indexed by initiator
  // A set bit means the path to that target exists
  // Initiator 1 cannot reach target 3
  localparam tgt_mask_t CONNECTIVITY [NUM_INIT] = '{
    4'b1111,
    4'b0111
  };

endpackage

/* mcast_xbar_tb.sv */
// Directed testbench for the multicast write crossbar; simulate with compile.f, top mcast_xbar_tb
module mcast_xbar_tb
  import mcast_xbar_pkg::*;
();

  // About ten times the cycles all tests take together
  localparam int TIMEOUT_CYC = 3000;
  localparam int LOG_DEPTH   = 16;
  localparam int STREAM_LEN  = 6;

  logic                 clk_i;
  logic                 arst_n_i;
  logic  [NUM_INIT-1:0] init_req_valid_i;
  addr_t [NUM_INIT-1:0] init_addr_i;
  addr_t [NUM_INIT-1:0] init_mask_i;
  data_t [NUM_INIT-1:0] init_data_i;
  logic  [NUM_INIT-1:0] init_req_ready_o;
  logic  [NUM_INIT-1:0] init_rsp_valid_o;
  resp_t [NUM_INIT-1:0] init_rsp_o;
  logic  [NUM_INIT-1:0] init_rsp_ready_i;
  tgt_mask_t            tgt_req_valid_o;
  addr_t [NUM_TGT-1:0]  tgt_addr_o;
  data_t [NUM_TGT-1:0]  tgt_data_o;
  tgt_mask_t            tgt_req_ready_i;
  tgt_mask_t            tgt_rsp_valid_i;
  resp_t [NUM_TGT-1:0]  tgt_rsp_i;
  tgt_mask_t            tgt_rsp_ready_o;

  // Requests seen by each target model
  addr_t log_addr [NUM_TGT][LOG_DEPTH];
  data_t log_data [NUM_TGT][LOG_DEPTH];
  int    log_cnt  [NUM_TGT];
  int    errors = 0;
  int    tests_failed = 0;
  int    cycles = 0;

  mcast_xbar_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYC) begin
      $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYC);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // Target models, ready after 0 to 3 cycles, SLVERR when data bit 31 is set
  for (genvar t = 0; t < NUM_TGT; t++) begin : gen_tgt_model
    initial begin
      int   dly;
      logic slverr;
      @(posedge arst_n_i);
      forever begin
        do @(negedge clk_i); while (!tgt_req_valid_o[t]);
        dly = $urandom_range(3, 0);
        repeat (dly + 1) @(posedge clk_i);
        #2;
        tgt_req_ready_i[t] = 1'b1;
        @(negedge clk_i);
        if (log_cnt[t] < LOG_DEPTH) begin
          log_addr[t][log_cnt[t]] = tgt_addr_o[t];
          log_data[t][log_cnt[t]] = tgt_data_o[t];
        end
        log_cnt[t] = log_cnt[t] + 1;
        slverr = tgt_data_o[t][31];
        @(posedge clk_i);
        #2;
        tgt_req_ready_i[t] = 1'b0;
        tgt_rsp_valid_i[t] = 1'b1;
        tgt_rsp_i[t]       = slverr ? RESP_SLVERR : RESP_OKAY;
        do @(negedge clk_i); while (!tgt_rsp_ready_o[t]);
        @(posedge clk_i);
        #2;
        tgt_rsp_valid_i[t] = 1'b0;
      end
    end
  end

  task automatic check_resp(input string name, input resp_t exp, input resp_t act);
    if (exp !== act) begin
      $display("Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic expect_count(input int t, input int exp);
    if (log_cnt[t] != exp) begin
      $display("Error at %0t: target %0d received %0d writes instead of %0d",
               $time, t, log_cnt[t], exp);
      errors++;
    end
  endtask

  task automatic clear_logs();
    for (int t = 0; t < NUM_TGT; t++) begin
      log_cnt[t] = 0;
    end
  endtask

  task automatic report_test(input string name, input int e0);
    if (errors == e0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: failed with %0d errors", name, errors - e0);
      tests_failed++;
    end
  endtask

  // Offer a request and return once it has transferred
  task automatic send_req(input int i, input addr_t addr, input addr_t mask, input data_t data);
    init_req_valid_i[i] = 1'b1;
    init_addr_i[i]      = addr;
    init_mask_i[i]      = mask;
    init_data_i[i]      = data;
    do @(negedge clk_i); while (!init_req_ready_o[i]);
    @(posedge clk_i);
    #2;
    init_req_valid_i[i] = 1'b0;
  endtask

  task automatic get_rsp(input int i, output resp_t rsp);
    do @(negedge clk_i); while (!(init_rsp_valid_o[i] && init_rsp_ready_i[i]));
    rsp = init_rsp_o[i];
    @(posedge clk_i);
    #2;
  endtask

  task automatic write_once(input int i, input addr_t addr, input addr_t mask,
                            input data_t data, output resp_t rsp);
    send_req(i, addr, mask, data);
    get_rsp(i, rsp);
  endtask

  task automatic test_unicast();
    int    e0;
    resp_t rsp;
    addr_t addr;
    data_t data;
    e0 = errors;
    for (int t = 0; t < NUM_TGT; t++) begin
      clear_logs();
      addr = MAP_BASE + addr_t'(t * TGT_SPAN) + 32'h40;
      data = 32'h1234_0000 + data_t'(t);
      write_once(0, addr, '0, data, rsp);
      check_resp("init_rsp_o[0]", RESP_OKAY, rsp);
      for (int u = 0; u < NUM_TGT; u++) begin
        expect_count(u, (u == t) ? 1 : 0);
      end
      check_addr($sformatf("tgt_addr_o[%0d]", t), addr, log_addr[t][0]);
      check_data($sformatf("tgt_data_o[%0d]", t), data, log_data[t][0]);
    end
    report_test("unicast", e0);
  endtask

  task automatic test_multicast();
    int    e0;
    resp_t rsp;
    addr_t addr;
    data_t data;
    e0 = errors;
    addr = MAP_BASE + 32'h100;
    for (int n = 0; n < 2; n++) begin
      clear_logs();
      data = (n == 0) ? 32'h0000_5a5a : 32'h8000_a5a5;
      // Mask wildcards both index bits
      write_once(0, addr, 32'h0000_3000, data, rsp);
      check_resp("init_rsp_o[0]", (n == 0) ? RESP_OKAY : RESP_SLVERR, rsp);
      for (int t = 0; t < NUM_TGT; t++) begin
        expect_count(t, 1);
        check_addr($sformatf("tgt_addr_o[%0d]", t), addr, log_addr[t][0]);
        check_data($sformatf("tgt_data_o[%0d]", t), data, log_data[t][0]);
      end
    end
    report_test("multicast", e0);
  endtask

  task automatic test_decode_error();
    int    e0;
    resp_t rsp;
    e0 = errors;
    clear_logs();
    write_once(0, 32'h0002_0000, '0, 32'h0000_0001, rsp);
    check_resp("init_rsp_o[0]", RESP_DECERR, rsp);
    // Initiator 1 has no path to target 3
    write_once(1, MAP_BASE + addr_t'(3 * TGT_SPAN), '0, 32'h0000_0002, rsp);
    check_resp("init_rsp_o[1]", RESP_DECERR, rsp);
    for (int t = 0; t < NUM_TGT; t++) begin
      expect_count(t, 0);
    end
    write_once(1, MAP_BASE + addr_t'(2 * TGT_SPAN) + 32'h20, 32'h0000_1000, 32'h3, rsp);
    check_resp("init_rsp_o[1]", RESP_OKAY, rsp);
    for (int t = 0; t < NUM_TGT; t++) begin
      expect_count(t, (t == 2) ? 1 : 0);
    end
    check_data("tgt_data_o[2]", 32'h0000_0003, log_data[2][0]);
    report_test("decode error", e0);
  endtask

  function automatic addr_t stream_addr(input int i, input int k);
    return MAP_BASE + addr_t'((k % 3) * TGT_SPAN) + addr_t'((i * 16 + k) * 4);
  endfunction

  function automatic data_t stream_data(input int i, input int k);
    return 32'h0c00_0000 + data_t'(i << 16) + data_t'(k);
  endfunction

  task automatic run_stream(input int i);
    resp_t rsp;
    for (int k = 0; k < STREAM_LEN; k++) begin
      write_once(i, stream_addr(i, k), '0, stream_data(i, k), rsp);
      check_resp($sformatf("init_rsp_o[%0d]", i), RESP_OKAY, rsp);
    end
  endtask

  task automatic test_contention();
    int e0;
    int hits;
    int t;
    e0 = errors;
    clear_logs();
    fork
      run_stream(0);
      run_stream(1);
    join
    for (int u = 0; u < NUM_TGT; u++) begin
      expect_count(u, (u < 3) ? 2 * STREAM_LEN / 3 : 0);
    end
    for (int i = 0; i < NUM_INIT; i++) begin
      for (int k = 0; k < STREAM_LEN; k++) begin
        t    = k % 3;
        hits = 0;
        for (int j = 0; j < log_cnt[t] && j < LOG_DEPTH; j++) begin
          if (log_addr[t][j] == stream_addr(i, k)) begin
            hits++;
            check_data($sformatf("tgt_data_o[%0d]", t), stream_data(i, k), log_data[t][j]);
          end
        end
        if (hits != 1) begin
          $display("Error at %0t: write %0d of initiator %0d reached target %0d %0d times",
                   $time, k, i, t, hits);
          errors++;
        end
      end
    end
    report_test("contention", e0);
  endtask

  task automatic test_backpressure();
    int    e0;
    resp_t rsp;
    e0 = errors;
    clear_logs();
    init_rsp_ready_i[0] = 1'b0;
    send_req(0, MAP_BASE + addr_t'(TGT_SPAN) + 32'h80, '0, 32'h8000_00aa);
    do @(negedge clk_i); while (!init_rsp_valid_o[0]);
    check_resp("init_rsp_o[0]", RESP_SLVERR, init_rsp_o[0]);
    // Second write waits behind the stalled response
    @(posedge clk_i);
    #2;
    init_req_valid_i[0] = 1'b1;
    init_addr_i[0]      = MAP_BASE + 32'h84;
    init_mask_i[0]      = '0;
    init_data_i[0]      = 32'h0000_00bb;
    repeat (5) begin
      @(negedge clk_i);
      if (!init_rsp_valid_o[0]) begin
        $display("Error at %0t: response valid dropped while stalled", $time);
        errors++;
      end
      check_resp("init_rsp_o[0]", RESP_SLVERR, init_rsp_o[0]);
      if (init_req_ready_o[0]) begin
        $display("Error at %0t: new request accepted before the response left", $time);
        errors++;
      end
    end
    @(posedge clk_i);
    #2;
    init_rsp_ready_i[0] = 1'b1;
    get_rsp(0, rsp);
    check_resp("init_rsp_o[0]", RESP_SLVERR, rsp);
    write_once(0, MAP_BASE + 32'h84, '0, 32'h0000_00bb, rsp);
    check_resp("init_rsp_o[0]", RESP_OKAY, rsp);
    expect_count(0, 1);
    expect_count(1, 1);
    check_data("tgt_data_o[0]", 32'h0000_00bb, log_data[0][0]);
    report_test("back-pressure", e0);
  endtask

  initial begin
    int seed;
    seed             = $urandom(32'hb29a);
    arst_n_i         = 1'b0;
    init_req_valid_i = '0;
    init_addr_i      = '0;
    init_mask_i      = '0;
    init_data_i      = '0;
    init_rsp_ready_i = '1;
    tgt_req_ready_i  = '0;
    tgt_rsp_valid_i  = '0;
    tgt_rsp_i        = '0;
    clear_logs();
    repeat (8) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;
    @(posedge clk_i);
    #2;
    test_unicast();
    test_multicast();
    test_decode_error();
    test_contention();
    test_backpressure();
    $display("Tests failed: %0d of 5, check errors: %0d, assertion failures: %0d",
             tests_failed, errors, uut.u_chk.fail_cnt);
    if (errors == 0 && uut.u_chk.fail_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* mcast_xbar_top.sv */
// Crossbar top level; two initiators reach four targets through decoders, demuxes and arbiters
module mcast_xbar_top
  import mcast_xbar_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Initiator ports
  input  logic  [NUM_INIT-1:0]  init_req_valid_i,
  input  addr_t [NUM_INIT-1:0]  init_addr_i,
  input  addr_t [NUM_INIT-1:0]  init_mask_i,
  input  data_t [NUM_INIT-1:0]  init_data_i,
  output logic  [NUM_INIT-1:0]  init_req_ready_o,
  output logic  [NUM_INIT-1:0]  init_rsp_valid_o,
  output resp_t [NUM_INIT-1:0]  init_rsp_o,
  input  logic  [NUM_INIT-1:0]  init_rsp_ready_i,
  // Target ports
  output tgt_mask_t             tgt_req_valid_o,
  output addr_t [NUM_TGT-1:0]   tgt_addr_o,
  output data_t [NUM_TGT-1:0]   tgt_data_o,
  input  tgt_mask_t             tgt_req_ready_i,
  input  tgt_mask_t             tgt_rsp_valid_i,
  input  resp_t [NUM_TGT-1:0]   tgt_rsp_i,
  output tgt_mask_t             tgt_rsp_ready_o
);

  // Demux side, indexed [initiator][target]
  tgt_mask_t [NUM_INIT-1:0]              dmx_req_valid;
  tgt_mask_t [NUM_INIT-1:0]              dmx_req_ready;
  addr_t     [NUM_INIT-1:0]              dmx_addr;
  data_t     [NUM_INIT-1:0]              dmx_data;
  tgt_mask_t [NUM_INIT-1:0]              dmx_rsp_valid;
  resp_t     [NUM_INIT-1:0][NUM_TGT-1:0] dmx_rsp;
  tgt_mask_t [NUM_INIT-1:0]              dmx_rsp_ready;

  // Arbiter side, indexed [target][initiator]
  logic      [NUM_TGT-1:0][NUM_INIT-1:0] arb_req_valid;
  logic      [NUM_TGT-1:0][NUM_INIT-1:0] arb_req_ready;
  logic      [NUM_TGT-1:0][NUM_INIT-1:0] arb_rsp_valid;
  resp_t     [NUM_TGT-1:0]               arb_rsp;
  logic      [NUM_TGT-1:0][NUM_INIT-1:0] arb_rsp_ready;

  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_init
    tgt_mask_t sel;
    logic      dec_err;

    mcast_addr_decoder #(
      .INIT_IDX ( init_idx_t'(i) )
    ) u_dec (
      .addr_i    ( init_addr_i[i] ),
      .mask_i    ( init_mask_i[i] ),
      .sel_o     ( sel            ),
      .dec_err_o ( dec_err        )
    );

    mcast_demux u_demux (
      .clk_i            ( clk_i               ),
      .arst_n_i         ( arst_n_i            ),
      .init_req_valid_i ( init_req_valid_i[i] ),
      .init_addr_i      ( init_addr_i[i]      ),
      .init_data_i      ( init_data_i[i]      ),
      .init_req_ready_o ( init_req_ready_o[i] ),
      .init_rsp_valid_o ( init_rsp_valid_o[i] ),
      .init_rsp_o       ( init_rsp_o[i]       ),
      .init_rsp_ready_i ( init_rsp_ready_i[i] ),
      .sel_i            ( sel                 ),
      .dec_err_i        ( dec_err             ),
      .req_valid_o      ( dmx_req_valid[i]    ),
      .req_ready_i      ( dmx_req_ready[i]    ),
      .addr_o           ( dmx_addr[i]         ),
      .data_o           ( dmx_data[i]         ),
      .rsp_valid_i      ( dmx_rsp_valid[i]    ),
      .rsp_i            ( dmx_rsp[i]          ),
      .rsp_ready_o      ( dmx_rsp_ready[i]    )
    );
  end

  // Transpose the paths; missing paths are tied off
  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_cross_init
    for (genvar t = 0; t < NUM_TGT; t++) begin : gen_cross_tgt
      assign dmx_rsp[i][t] = arb_rsp[t];
      if (CONNECTIVITY[i][t]) begin : gen_path
        assign arb_req_valid[t][i] = dmx_req_valid[i][t];
        assign dmx_req_ready[i][t] = arb_req_ready[t][i];
        assign dmx_rsp_valid[i][t] = arb_rsp_valid[t][i];
        assign arb_rsp_ready[t][i] = dmx_rsp_ready[i][t];
      end else begin : gen_no_path
        assign arb_req_valid[t][i] = 1'b0;
        assign dmx_req_ready[i][t] = 1'b0;
        assign dmx_rsp_valid[i][t] = 1'b0;
        assign arb_rsp_ready[t][i] = 1'b0;
      end
    end
  end

  for (genvar t = 0; t < NUM_TGT; t++) begin : gen_tgt
    mcast_arbiter u_arb (
      .clk_i           ( clk_i              ),
      .arst_n_i        ( arst_n_i           ),
      .req_valid_i     ( arb_req_valid[t]   ),
      .req_ready_o     ( arb_req_ready[t]   ),
      .addr_i          ( dmx_addr           ),
      .data_i          ( dmx_data           ),
      .rsp_valid_o     ( arb_rsp_valid[t]   ),
      .rsp_o           ( arb_rsp[t]         ),
      .rsp_ready_i     ( arb_rsp_ready[t]   ),
      .tgt_req_valid_o ( tgt_req_valid_o[t] ),
      .tgt_addr_o      ( tgt_addr_o[t]      ),
      .tgt_data_o      ( tgt_data_o[t]      ),
      .tgt_req_ready_i ( tgt_req_ready_i[t] ),
      .tgt_rsp_valid_i ( tgt_rsp_valid_i[t] ),
      .tgt_rsp_i       ( tgt_rsp_i[t]       ),
      .tgt_rsp_ready_o ( tgt_rsp_ready_o[t] )
    );
  end

endmodule
